// ==== cpu_pkg.sv ====
// cpu widths, instruction field positions, reset address, opcode and forwarding enums
package cpu_pkg;

    localparam int data_w     = 32;
    localparam int reg_addr_w = 4;
    // 256-word program ROM
    localparam int rom_addr_w = 8;
    localparam int op_w       = 6;

    localparam logic [data_w-1:0] reset_pc = '0;

    ////////////////////////////////////////////////////////////////////////////
    // instruction fields
    ////////////////////////////////////////////////////////////////////////////

    localparam int op_msb  = 31;
    localparam int op_lsb  = 26;
    localparam int rd_msb  = 25;
    localparam int rd_lsb  = 22;
    localparam int rs0_msb = 21;
    localparam int rs0_lsb = 18;
    localparam int rs1_msb = 17;
    localparam int rs1_lsb = 14;
    // immediate sits in the low bits, overlapping rs1
    localparam int imm_w   = 16;

    // an all-zero word decodes as nop
    typedef enum logic [op_w-1:0] {
        op_nop  = 6'h00,
        op_add  = 6'h01,
        op_sub  = 6'h02,
        op_and  = 6'h03,
        op_or   = 6'h04,
        op_xor  = 6'h05,
        op_addi = 6'h06,
        op_beq  = 6'h07,
        op_jmp  = 6'h08,
        op_in   = 6'h09,
        op_out  = 6'h0a
    } opcode_t;

    // operand source for decode
    typedef enum logic [1:0] {
        fwd_rf  = 2'd0,
        fwd_ex  = 2'd1,
        fwd_mem = 2'd2
    } fwd_sel_t;

endpackage

// ==== inst_rom.sv ====
// synchronous instruction ROM loaded from prog.hex
`timescale 1ns/1ns

module inst_rom (
    input  logic                            clk,
    input  logic [cpu_pkg::rom_addr_w-1:0]  raddr,
    output logic [cpu_pkg::data_w-1:0]      dout
);
    import cpu_pkg::*;

    logic [data_w-1:0] mem [0:(1 << rom_addr_w)-1];

    initial begin
        $readmemh("prog.hex", mem);
    end

    // data shows up one cycle after the address
    always_ff @(posedge clk) begin
        dout <= mem[raddr];
    end

endmodule

// ==== register_file.sv ====
// sixteen-entry register file, two combinational read ports with write-through
`timescale 1ns/1ns

module register_file (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic [cpu_pkg::reg_addr_w-1:0]  raddr0,
    input  logic [cpu_pkg::reg_addr_w-1:0]  raddr1,
    input  logic                            we,
    input  logic [cpu_pkg::reg_addr_w-1:0]  waddr,
    input  logic [cpu_pkg::data_w-1:0]      wdata,
    output logic [cpu_pkg::data_w-1:0]      rdata0,
    output logic [cpu_pkg::data_w-1:0]      rdata1
);
    import cpu_pkg::*;

    logic [data_w-1:0] regs [0:(1 << reg_addr_w)-1];

    // r0 reads as zero; a same-cycle write is seen by the reader
    function automatic logic [data_w-1:0] read_port(input logic [reg_addr_w-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (we && waddr == addr) begin
            return wdata;
        end
        return regs[addr];
    endfunction

    assign rdata0 = read_port(raddr0);
    assign rdata1 = read_port(raddr1);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < (1 << reg_addr_w); i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

// ==== fetch.sv ====
// program counter and ROM address generation with stall and redirect
`timescale 1ns/1ns

module fetch (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            stall,
    input  logic                            redirect,
    input  logic [cpu_pkg::data_w-1:0]      target,
    output logic [cpu_pkg::rom_addr_w-1:0]  rom_addr,
    output logic [cpu_pkg::data_w-1:0]      pc_out
);
    import cpu_pkg::*;

    // next address to fetch, one word past the instruction in decode
    logic [data_w-1:0] pc;

    // under stall re-read the word decode is holding, since the ROM has no enable
    assign pc_out   = (stall && !redirect) ? pc - data_w'(4) : pc;
    assign rom_addr = pc_out[rom_addr_w+1:2];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc <= reset_pc;
        end else if (redirect) begin
            pc <= target;
        end else if (!stall) begin
            pc <= pc + data_w'(4);
        end
    end

endmodule

// ==== decode.sv ====
// field extraction, source register selection, operand forwarding muxes, opcode decode
`timescale 1ns/1ns

module decode (
    input  logic [cpu_pkg::data_w-1:0]      pc,
    input  logic [cpu_pkg::data_w-1:0]      instr,
    input  logic [cpu_pkg::data_w-1:0]      rs0data,
    input  logic [cpu_pkg::data_w-1:0]      rs1data,
    input  logic [cpu_pkg::data_w-1:0]      alu_fwd,
    input  logic [cpu_pkg::data_w-1:0]      mem_fwd,
    input  cpu_pkg::fwd_sel_t               fwd0,
    input  cpu_pkg::fwd_sel_t               fwd1,
    output logic [cpu_pkg::reg_addr_w-1:0]  rs0,
    output logic [cpu_pkg::reg_addr_w-1:0]  rs1,
    output cpu_pkg::opcode_t                op,
    output logic [cpu_pkg::reg_addr_w-1:0]  rd,
    output logic [cpu_pkg::data_w-1:0]      imm,
    output logic [cpu_pkg::data_w-1:0]      pc_out,
    output logic [cpu_pkg::data_w-1:0]      opa,
    output logic [cpu_pkg::data_w-1:0]      opb
);
    import cpu_pkg::*;

    logic [op_w-1:0]       f_op;
    logic [reg_addr_w-1:0] f_rs0;
    logic [reg_addr_w-1:0] f_rs1;

    function automatic logic [data_w-1:0] pick(input fwd_sel_t sel,
                                               input logic [data_w-1:0] rf_val);
        case (sel)
            fwd_ex:  return alu_fwd;
            fwd_mem: return mem_fwd;
            default: return rf_val;
        endcase
    endfunction

    assign f_op   = instr[op_msb:op_lsb];
    assign rd     = instr[rd_msb:rd_lsb];
    assign f_rs0  = instr[rs0_msb:rs0_lsb];
    assign f_rs1  = instr[rs1_msb:rs1_lsb];
    assign imm    = {{(data_w-imm_w){instr[imm_w-1]}}, instr[imm_w-1:0]};
    assign pc_out = pc;

    // unknown codes become nop
    always_comb begin
        case (f_op)
            op_add, op_sub, op_and, op_or, op_xor,
            op_addi, op_beq, op_jmp, op_in, op_out: begin
                op = opcode_t'(f_op);
            end
            default: begin
                op = op_nop;
            end
        endcase
    end

    // unused sources read r0 so they never match a hazard
    always_comb begin
        rs0 = '0;
        rs1 = '0;
        case (op)
            op_add, op_sub, op_and, op_or, op_xor: begin
                rs0 = f_rs0;
                rs1 = f_rs1;
            end
            op_addi, op_out: begin
                rs0 = f_rs0;
            end
            // beq compares rd against rs0
            op_beq: begin
                rs0 = f_rs0;
                rs1 = rd;
            end
            default: begin
            end
        endcase
    end

    assign opa = pick(fwd0, rs0data);
    assign opb = (op == op_addi) ? imm : pick(fwd1, rs1data);

endmodule

// ==== exec.sv ====
// ALU, branch compare and redirect target
`timescale 1ns/1ns

module exec (
    input  cpu_pkg::opcode_t                op,
    input  logic [cpu_pkg::reg_addr_w-1:0]  rd,
    input  logic [cpu_pkg::data_w-1:0]      imm,
    input  logic [cpu_pkg::data_w-1:0]      pc,
    input  logic [cpu_pkg::data_w-1:0]      opa,
    input  logic [cpu_pkg::data_w-1:0]      opb,
    output logic [cpu_pkg::data_w-1:0]      result,
    output logic [cpu_pkg::reg_addr_w-1:0]  out_rd,
    output cpu_pkg::opcode_t                out_op,
    output logic                            out_we,
    output logic                            redirect,
    output logic [cpu_pkg::data_w-1:0]      target
);
    import cpu_pkg::*;

    // word offset to byte offset
    logic [data_w-1:0] imm_x4;

    assign imm_x4 = {imm[data_w-3:0], 2'b00};
    assign out_rd = rd;
    assign out_op = op;

    always_comb begin
        result   = '0;
        out_we   = 1'b0;
        redirect = 1'b0;
        target   = imm_x4;
        case (op)
            op_add, op_addi: begin
                result = opa + opb;
                out_we = 1'b1;
            end
            op_sub: begin
                result = opa - opb;
                out_we = 1'b1;
            end
            op_and: begin
                result = opa & opb;
                out_we = 1'b1;
            end
            op_or: begin
                result = opa | opb;
                out_we = 1'b1;
            end
            op_xor: begin
                result = opa ^ opb;
                out_we = 1'b1;
            end
            // relative to the branch's own pc
            op_beq: begin
                redirect = (opa == opb);
                target   = pc + imm_x4;
            end
            op_jmp: begin
                redirect = 1'b1;
            end
            // value arrives in the memory stage
            op_in: begin
                out_we = 1'b1;
            end
            op_out: begin
                result = opa;
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== io_stage.sv ====
// memory stage: IN and OUT on the FIFO ports, back-pressure and write-back value
`timescale 1ns/1ns

module io_stage (
    input  cpu_pkg::opcode_t                op,
    input  logic [cpu_pkg::reg_addr_w-1:0]  rd,
    input  logic                            we,
    input  logic [cpu_pkg::data_w-1:0]      value,
    input  logic [7:0]                      uart_rx_data,
    input  logic                            empty,
    input  logic                            full,
    output logic                            uart_rd_en,
    output logic                            uart_wr_en,
    output logic [7:0]                      uart_tx_data,
    output logic                            mem_wait,
    output logic [cpu_pkg::reg_addr_w-1:0]  wb_rd,
    output logic                            wb_we,
    output logic [cpu_pkg::data_w-1:0]      wb_data
);
    import cpu_pkg::*;

    logic is_in;
    logic is_out;

    assign is_in  = (op == op_in);
    assign is_out = (op == op_out);

    // rx is fall-through, so the head byte is valid whenever empty is low
    assign uart_rd_en   = is_in && !empty;
    assign uart_wr_en   = is_out && !full;
    assign uart_tx_data = value[7:0];

    assign mem_wait = (is_in && empty) || (is_out && full);

    // no write while waiting, the stage repeats next cycle
    assign wb_rd   = rd;
    assign wb_we   = we && !mem_wait;
    assign wb_data = is_in ? data_w'(uart_rx_data) : value;

endmodule

// ==== hazard_unit.sv ====
// forwarding selects and load-use stall detection
`timescale 1ns/1ns

module hazard_unit (
    input  logic [cpu_pkg::reg_addr_w-1:0]  rs0,
    input  logic [cpu_pkg::reg_addr_w-1:0]  rs1,
    input  logic [cpu_pkg::reg_addr_w-1:0]  ex_rd,
    input  logic                            ex_we,
    input  logic                            ex_is_in,
    input  logic [cpu_pkg::reg_addr_w-1:0]  mem_rd,
    input  logic                            mem_we,
    output cpu_pkg::fwd_sel_t               fwd0,
    output cpu_pkg::fwd_sel_t               fwd1,
    output logic                            lwstall
);
    import cpu_pkg::*;

    // youngest producer wins, r0 is never forwarded
    function automatic fwd_sel_t select(input logic [reg_addr_w-1:0] rs);
        if (rs == '0) begin
            return fwd_rf;
        end
        if (ex_we && ex_rd == rs) begin
            return fwd_ex;
        end
        if (mem_we && mem_rd == rs) begin
            return fwd_mem;
        end
        return fwd_rf;
    endfunction

    assign fwd0 = select(rs0);
    assign fwd1 = select(rs1);

    // IN data exists only in the memory stage
    assign lwstall = ex_is_in && ex_we && (ex_rd != '0) &&
                     (ex_rd == rs0 || ex_rd == rs1);

endmodule

// ==== cpu.sv ====
// five-stage cpu top: pipeline registers, writeback, stall and flush control
`timescale 1ns/1ns

module cpu (
    input  logic       clk,
    input  logic       rstn,
    // receive FIFO
    input  logic [7:0] uart_rx_data,
    input  logic       empty,
    output logic       uart_rd_en,
    // transmit FIFO
    output logic [7:0] uart_tx_data,
    input  logic       full,
    output logic       uart_wr_en
);
    import cpu_pkg::*;

    // fetch
    logic [rom_addr_w-1:0] rom_addr;
    logic [data_w-1:0]     rom_dout;
    logic [data_w-1:0]     pc_f;

    // fetch/decode, the instruction half is the ROM output register
    logic [data_w-1:0]     pc_fd;
    logic                  fd_valid;
    logic [data_w-1:0]     instr_d;

    // decode
    logic [reg_addr_w-1:0] rs0;
    logic [reg_addr_w-1:0] rs1;
    logic [data_w-1:0]     rs0_data;
    logic [data_w-1:0]     rs1_data;
    fwd_sel_t              fwd0;
    fwd_sel_t              fwd1;
    opcode_t               op_d;
    logic [reg_addr_w-1:0] rd_d;
    logic [data_w-1:0]     imm_d;
    logic [data_w-1:0]     pc_d;
    logic [data_w-1:0]     opa_d;
    logic [data_w-1:0]     opb_d;

    // decode/execute
    opcode_t               op_de;
    logic [reg_addr_w-1:0] rd_de;
    logic [data_w-1:0]     imm_de;
    logic [data_w-1:0]     pc_de;
    logic [data_w-1:0]     opa_de;
    logic [data_w-1:0]     opb_de;

    // execute
    logic [data_w-1:0]     ex_result;
    logic [reg_addr_w-1:0] ex_rd;
    opcode_t               ex_op;
    logic                  ex_we;
    logic                  ex_redirect;
    logic [data_w-1:0]     ex_target;

    // execute/memory
    opcode_t               op_em;
    logic [reg_addr_w-1:0] rd_em;
    logic                  we_em;
    logic [data_w-1:0]     result_em;

    // memory
    logic [reg_addr_w-1:0] mem_rd;
    logic                  mem_we;
    logic [data_w-1:0]     mem_data;
    logic                  mem_wait;

    // memory/writeback
    logic [reg_addr_w-1:0] wb_rd;
    logic                  wb_we;
    logic [data_w-1:0]     wb_data;

    logic                  lwstall;
    logic                  redirect;
    logic                  stall_front;

    ////////////////////////////////////////////////////////////////////////////
    // stall and flush control
    ////////////////////////////////////////////////////////////////////////////

    // a frozen branch stays in execute and redirects once the pipe moves
    assign redirect    = ex_redirect && !mem_wait;
    assign stall_front = lwstall || mem_wait;

    ////////////////////////////////////////////////////////////////////////////
    // fetch and decode
    ////////////////////////////////////////////////////////////////////////////

    fetch u_fetch (
        .clk      (clk),
        .rstn     (rstn),
        .stall    (stall_front),
        .redirect (redirect),
        .target   (ex_target),
        .rom_addr (rom_addr),
        .pc_out   (pc_f)
    );

    inst_rom u_rom (
        .clk   (clk),
        .raddr (rom_addr),
        .dout  (rom_dout)
    );

    // flush drops the ROM word arriving next cycle
    always_ff @(posedge clk) begin
        if (!rstn) begin
            fd_valid <= 1'b0;
        end else if (redirect) begin
            fd_valid <= 1'b0;
        end else if (!stall_front) begin
            fd_valid <= 1'b1;
            pc_fd    <= pc_f;
        end
    end

    assign instr_d = fd_valid ? rom_dout : '0;

    decode u_decode (
        .pc      (pc_fd),
        .instr   (instr_d),
        .rs0data (rs0_data),
        .rs1data (rs1_data),
        .alu_fwd (ex_result),
        .mem_fwd (mem_data),
        .fwd0    (fwd0),
        .fwd1    (fwd1),
        .rs0     (rs0),
        .rs1     (rs1),
        .op      (op_d),
        .rd      (rd_d),
        .imm     (imm_d),
        .pc_out  (pc_d),
        .opa     (opa_d),
        .opb     (opb_d)
    );

    register_file u_regfile (
        .clk    (clk),
        .rstn   (rstn),
        .raddr0 (rs0),
        .raddr1 (rs1),
        .we     (wb_we),
        .waddr  (wb_rd),
        .wdata  (wb_data),
        .rdata0 (rs0_data),
        .rdata1 (rs1_data)
    );

    hazard_unit u_hazard (
        .rs0      (rs0),
        .rs1      (rs1),
        .ex_rd    (ex_rd),
        .ex_we    (ex_we),
        .ex_is_in (ex_op == op_in),
        .mem_rd   (mem_rd),
        .mem_we   (mem_we),
        .fwd0     (fwd0),
        .fwd1     (fwd1),
        .lwstall  (lwstall)
    );

    // bubble on flush or load-use, hold on back-pressure
    always_ff @(posedge clk) begin
        if (!rstn) begin
            op_de <= op_nop;
        end else if (!mem_wait) begin
            if (redirect || lwstall) begin
                op_de <= op_nop;
            end else begin
                op_de  <= op_d;
                rd_de  <= rd_d;
                imm_de <= imm_d;
                pc_de  <= pc_d;
                opa_de <= opa_d;
                opb_de <= opb_d;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // execute, memory and writeback
    ////////////////////////////////////////////////////////////////////////////

    exec u_exec (
        .op       (op_de),
        .rd       (rd_de),
        .imm      (imm_de),
        .pc       (pc_de),
        .opa      (opa_de),
        .opb      (opb_de),
        .result   (ex_result),
        .out_rd   (ex_rd),
        .out_op   (ex_op),
        .out_we   (ex_we),
        .redirect (ex_redirect),
        .target   (ex_target)
    );

    always_ff @(posedge clk) begin
        if (!rstn) begin
            op_em <= op_nop;
            we_em <= 1'b0;
        end else if (!mem_wait) begin
            op_em     <= ex_op;
            we_em     <= ex_we;
            rd_em     <= ex_rd;
            result_em <= ex_result;
        end
    end

    io_stage u_io (
        .op           (op_em),
        .rd           (rd_em),
        .we           (we_em),
        .value        (result_em),
        .uart_rx_data (uart_rx_data),
        .empty        (empty),
        .full         (full),
        .uart_rd_en   (uart_rd_en),
        .uart_wr_en   (uart_wr_en),
        .uart_tx_data (uart_tx_data),
        .mem_wait     (mem_wait),
        .wb_rd        (mem_rd),
        .wb_we        (mem_we),
        .wb_data      (mem_data)
    );

    // takes a bubble while memory waits, mem_we is already low then
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wb_we <= 1'b0;
        end else begin
            wb_we   <= mem_we;
            wb_rd   <= mem_rd;
            wb_data <= mem_data;
        end
    end

endmodule

// ==== tb_cpu.sv ====
// cpu testbench with receive FIFO model, transmit monitor, LFSR and directed tests
`timescale 1ns/1ns

module tb_cpu;

    logic        clk = 1'b0;
    logic        rstn;
    logic [7:0]  uart_rx_data;
    logic        empty;
    logic        uart_rd_en;
    logic [7:0]  uart_tx_data;
    logic        full;
    logic        uart_wr_en;

    logic [7:0]  rx_q[$];
    logic [7:0]  tx_log[$];
    logic [7:0]  exp_log[$];
    logic        rd_seen = 1'b0;
    logic        full_mode = 1'b0;
    logic [31:0] lfsr = 32'h33ccdf8c;
    int          cycles = 0;

    cpu dut (
        .clk          (clk),
        .rstn         (rstn),
        .uart_rx_data (uart_rx_data),
        .empty        (empty),
        .uart_rd_en   (uart_rd_en),
        .uart_tx_data (uart_tx_data),
        .full         (full),
        .uart_wr_en   (uart_wr_en)
    );

    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function logic coin();
        lfsr = lfsr_step(lfsr);
        return lfsr[0];
    endfunction

    function logic [7:0] random_byte();
        logic [7:0] v;
        v = 8'h00;
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[6:0], lfsr[0]};
        end
        return v;
    endfunction

    task fail_now();
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    // program output per round is sum, xor, difference and the equal flag byte
    task push_expected(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] sum;
        logic [7:0] diff;
        sum = a + b;
        diff = a - b;
        exp_log.push_back(sum);
        exp_log.push_back(a ^ b);
        exp_log.push_back(diff);
        exp_log.push_back((a == b) ? 8'hee : 8'h11);
    endtask

    task queue_round(input logic [7:0] a, input logic [7:0] b);
        @(negedge clk);
        rx_q.push_back(a);
        rx_q.push_back(b);
        push_expected(a, b);
    endtask

    task apply_reset();
        @(negedge clk);
        rx_q.delete();
        full_mode = 1'b0;
        @(posedge clk);
        #1 rstn = 1'b0;
        repeat (5) @(posedge clk);
        #1 rstn = 1'b1;
    endtask

    // waits for the expected count, then a quiet spell to catch extra bytes
    task compare_stream();
        while (tx_log.size() < exp_log.size()) @(posedge clk);
        repeat (20) @(posedge clk);
        assert (tx_log.size() == exp_log.size()) else begin
            $display("** Error at %0t: %0d bytes sent, %0d expected",
                     $time, tx_log.size(), exp_log.size());
            fail_now();
        end
        for (int i = 0; i < exp_log.size(); i++) begin
            assert (tx_log[i] == exp_log[i]) else begin
                $display("** Error at %0t: byte %0d is %02h, expected %02h",
                         $time, i, tx_log[i], exp_log[i]);
                fail_now();
            end
        end
    endtask

    task check_idle(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            assert (!uart_rd_en && !uart_wr_en) else begin
                $display("** Error at %0t: FIFO enable active while idle, rd_en %b wr_en %b",
                         $time, uart_rd_en, uart_wr_en);
                fail_now();
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // FIFO models and watchdog
    ////////////////////////////////////////////////////////////////////////////

    // fall-through receive FIFO whose outputs change just after the edge
    always @(posedge clk) begin
        #1;
        if (rd_seen && rx_q.size() > 0) begin
            void'(rx_q.pop_front());
        end
        empty = (rx_q.size() == 0);
        uart_rx_data = empty ? 8'h00 : rx_q[0];
        full = full_mode ? coin() : 1'b0;
    end

    always @(negedge clk) begin
        rd_seen = uart_rd_en;
        assert (!(uart_wr_en && full)) else begin
            $display("** Error at %0t: uart_wr_en raised while full is high", $time);
            fail_now();
        end
        if (uart_wr_en && !full) begin
            tx_log.push_back(uart_tx_data);
        end
    end

    // about four times the longest run
    always @(posedge clk) begin
        cycles++;
        if (cycles >= 20000) begin
            $display("timeout: run did not finish within 20000 cycles");
            $display("tests failed");
            $fatal(1, "watchdog expired");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////

    task test_reset_state();
        apply_reset();
        check_idle(50);
    endtask

    task test_arith();
        queue_round(8'h03, 8'h05);
        queue_round(8'hc8, 8'h64);
        queue_round(8'h5a, 8'ha5);
        queue_round(8'h0a, 8'h14);
        compare_stream();
    endtask

    task test_branch();
        queue_round(8'h07, 8'h07);
        queue_round(8'h07, 8'h08);
        queue_round(8'h00, 8'h00);
        queue_round(8'hff, 8'hff);
        queue_round(8'hff, 8'h00);
        compare_stream();
    endtask

    task test_starvation();
        @(negedge clk);
        rx_q.push_back(8'h42);
        while (rx_q.size() != 0) @(posedge clk);
        check_idle(30);
        @(negedge clk);
        rx_q.push_back(8'h17);
        push_expected(8'h42, 8'h17);
        compare_stream();
    endtask

    task test_backpressure();
        logic [7:0] pa[20];
        logic [7:0] pb[20];
        for (int i = 0; i < 20; i++) begin
            pa[i] = random_byte();
            pb[i] = random_byte();
            // some equal pairs for the branch path
            if (i % 5 == 0) begin
                pb[i] = pa[i];
            end
        end
        @(negedge clk);
        full_mode = 1'b1;
        for (int i = 0; i < 20; i++) begin
            queue_round(pa[i], pb[i]);
        end
        compare_stream();
        @(negedge clk);
        full_mode = 1'b0;
    endtask

    // reset while the program holds a consumed first operand
    task test_mid_reset();
        @(negedge clk);
        rx_q.push_back(8'h21);
        while (rx_q.size() != 0) @(posedge clk);
        repeat (5) @(posedge clk);
        apply_reset();
        check_idle(10);
        queue_round(8'h30, 8'h0c);
        compare_stream();
    endtask

    initial begin
        rstn = 1'b0;
        empty = 1'b1;
        uart_rx_data = 8'h00;
        full = 1'b0;
        test_reset_state();
        test_arith();
        test_branch();
        test_starvation();
        test_backpressure();
        test_mid_reset();
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== prog.hex ====
// one 32-bit instruction word per line: op[31:26] rd[25:22] rs0[21:18] rs1[17:14] imm[15:0]
24400000
24800000
04C48000
280C0000
15048000
09448000
28100000
28140000
1C480004
19800011
28180000
20000000
198000EE
28180000
20000000
00000000
00000000
00000000
00000000

// ==== sim.f ====
cpu_pkg.sv
inst_rom.sv
register_file.sv
fetch.sv
decode.sv
exec.sv
io_stage.sv
hazard_unit.sv
cpu.sv
tb_cpu.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cpu testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_cpu -o tb_cpu_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/tb_cpu_sim > sim.log 2>&1
run_status=$?

if grep -q "tests failed" sim.log; then
    echo "FAIL: see sim.log"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "FAIL: simulator exited with status $run_status"
    exit 1
fi
if ! grep -q "all tests passed" sim.log; then
    echo "FAIL: no pass line in sim.log"
    exit 1
fi
echo "PASS"
exit 0
